// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= perf_arb_mem_tb
SEED_ARGS ?=
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

SRCS := $(wildcard hdl/*.sv) $(wildcard dv/*.sv)

.PHONY: all run clean

all: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V%: $(FILELIST) $(SRCS)
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $* \
		-Mdir $(OBJ_DIR) -o V$*

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/perf_arb_mem_tb.sv ====
`timescale 1ns/1ps

module perf_arb_mem_tb;
  import perf_pkg::*;

  localparam int clk_period   = 40;
  localparam int num_runs     = 5;
  localparam int zero_run     = 3;
  localparam int max_count    = 300;
  localparam int byte_timeout = 4 * max_count * num_gen;
  localparam int done_timeout = 4 * clks_per_bit;
  localparam longint watchdog_ns = longint'(num_runs)
    * (4 * max_count + 10 * report_bytes * clks_per_bit) * clk_period * 2;

  logic              clk;
  logic              rst_n;
  logic              start;
  logic [15:0]       write_count;
  logic [addr_w-1:0] dbg_addr;
  logic [data_w-1:0] dbg_data;
  logic              done;
  logic              utx_pin;

  // the shadow keeps every word the generators have written across all runs.
  logic [data_w-1:0] shadow_mem [mem_depth];
  bit                written [mem_depth];
  gen_stats_t        exp_stats [num_gen];
  logic [31:0]       lcg_state;
  int                test_errors;
  int                tests_passed;
  int                tests_failed;

  perf_arb_mem UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .write_count(write_count),
    .dbg_addr   (dbg_addr),
    .dbg_data   (dbg_data),
    .done       (done),
    .utx_pin    (utx_pin)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] lfsr_advance(logic [15:0] v);
    if (v[0]) begin
      return (v >> 1) ^ lfsr_taps;
    end
    return v >> 1;
  endfunction

  task automatic model_run(input logic [15:0] wc);
    logic [data_w-1:0] v;
    logic [addr_w-1:0] a;
    for (int g = 0; g < num_gen; g++) begin
      v = lfsr_seed ^ data_w'(g);
      exp_stats[g] = '0;
      exp_stats[g].count = wc;
      for (int k = 0; k < int'(wc); k++) begin
        a = {gen_w'(g), v[addr_w-gen_w-1:0]};
        shadow_mem[a] = v;
        written[a] = 1'b1;
        exp_stats[g].checksum = exp_stats[g].checksum ^ v;
        v = lfsr_advance(v);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [data_w-1:0] expected,
                            input logic [data_w-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_stats(input string name, input gen_stats_t expected,
                             input gen_stats_t actual);
    if (actual !== expected) begin
      $display("FAILED %s expected count %h checksum %h actual count %h checksum %h",
               name, expected.count, expected.checksum, actual.count, actual.checksum);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d error(s)", name, test_errors);
    end
  endtask

  //////////////////////////////////////////////////
  // bus drivers and the uart receiver
  //////////////////////////////////////////////////

  task automatic drive_start(input logic [15:0] wc);
    @(posedge clk);
    #2;
    write_count = wc;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic read_word(input logic [addr_w-1:0] a, output logic [data_w-1:0] d);
    @(posedge clk);
    #2;
    dbg_addr = a;
    @(posedge clk);
    #2;
    d = dbg_data;
  endtask

  // the line is polled on the falling clock edge to stay away from its transitions.
  task automatic receive_byte(output logic [7:0] b, output bit ok);
    int waited;
    ok = 1'b0;
    b = '0;
    waited = 0;
    @(negedge clk);
    while (utx_pin !== 1'b0 && waited < byte_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (utx_pin !== 1'b0) begin
      $display("no start bit on utx_pin within %0d cycles", byte_timeout);
      return;
    end
    repeat (clks_per_bit / 2 - 1) @(negedge clk);
    if (utx_pin !== 1'b0) begin
      $display("start bit on utx_pin ended before its middle");
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      b[i] = utx_pin;
    end
    repeat (clks_per_bit) @(negedge clk);
    if (utx_pin !== 1'b1) begin
      $display("stop bit missing on utx_pin");
      return;
    end
    ok = 1'b1;
  endtask

  task automatic wait_done(output bit ok);
    int waited;
    waited = 0;
    @(negedge clk);
    while (done !== 1'b1 && waited < done_timeout) begin
      @(negedge clk);
      waited++;
    end
    ok = (done === 1'b1);
    if (!ok) begin
      $display("done did not rise within %0d cycles after the report frame", done_timeout);
    end
  endtask

  task automatic check_memory(input int run);
    logic [data_w-1:0] got;
    for (int a = 0; a < mem_depth; a++) begin
      if (written[a]) begin
        read_word(addr_w'(a), got);
        check_word($sformatf("run%0d_memory addr %02h", run, a), shadow_mem[a], got);
      end
    end
  endtask

  task automatic execute_run(input int run, input logic [15:0] wc);
    logic [7:0] frame_bytes [report_bytes];
    logic [7:0] rx;
    bit         ok;
    bit         frame_ok;
    bit         cleared;
    gen_stats_t got;
    model_run(wc);
    drive_start(wc);
    cleared = (done === 1'b0);
    if (!cleared) begin
      $display("done did not drop after start in run %0d", run);
    end
    frame_ok = 1'b1;
    for (int i = 0; i < report_bytes; i++) begin
      if (frame_ok) begin
        receive_byte(rx, ok);
        frame_bytes[i] = rx;
        frame_ok = ok;
      end
    end
    wait_done(ok);
    test_errors = 0;
    if (!frame_ok || !ok || !cleared) begin
      test_errors++;
    end
    if (frame_ok) begin
      check_byte($sformatf("run%0d_report header", run), report_header, frame_bytes[0]);
      for (int g = 0; g < num_gen; g++) begin
        got.count    = {frame_bytes[4*g+1], frame_bytes[4*g+2]};
        got.checksum = {frame_bytes[4*g+3], frame_bytes[4*g+4]};
        check_stats($sformatf("run%0d_report gen%0d", run, g), exp_stats[g], got);
      end
    end
    finish_test($sformatf("run%0d_report write_count %0d", run, wc));
    test_errors = 0;
    check_memory(run);
    finish_test($sformatf("run%0d_memory", run));
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [15:0] wc;
    rst_n        = 1'b0;
    start        = 1'b0;
    write_count  = '0;
    dbg_addr     = '0;
    lcg_state    = 32'hb33c;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int a = 0; a < mem_depth; a++) begin
      written[a] = 1'b0;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // one run uses a zero count and the others draw a count from 1 to max_count.
    for (int run = 0; run < num_runs; run++) begin
      if (run == zero_run) begin
        wc = 16'd0;
      end else begin
        lcg_state = lcg_next(lcg_state);
        wc = 16'(1 + (lcg_state[31:8] % max_count));
      end
      execute_run(run, wc);
    end

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before the tests completed", watchdog_ns);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== hdl/perf_arb_mem.sv ====
`timescale 1ns/1ps

module perf_arb_mem (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [15:0]                 write_count,
  input  logic [perf_pkg::addr_w-1:0] dbg_addr,
  output logic [perf_pkg::data_w-1:0] dbg_data,
  output logic                        done,
  output logic                        utx_pin
);
  import perf_pkg::*;

  logic [num_gen-1:0] gen_req_valid;
  wr_req_t            gen_req [num_gen];
  logic [num_gen-1:0] gen_req_ready;
  logic [num_gen-1:0] gen_resp_valid;
  logic [num_gen-1:0] gen_resp_ready;
  gen_stats_t         gen_stats [num_gen];
  logic [num_gen-1:0] gen_done;

  logic               mem_req_valid;
  wr_req_t            mem_req;
  logic [gen_w-1:0]   mem_req_gen;
  logic               mem_req_ready;
  logic               mem_resp_valid;
  wr_resp_t           mem_resp;
  logic               mem_resp_ready;

  logic               tx_valid;
  logic [7:0]         tx_byte;
  logic               tx_ready;

  //////////////////////////////////////////////////
  // traffic sources
  //////////////////////////////////////////////////

  for (genvar i = 0; i < num_gen; i++) begin : g_gen
    perf_traffic_gen #(
      .gen_id(i)
    ) traffic_gen_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .write_count(write_count),
      .req_valid  (gen_req_valid[i]),
      .req        (gen_req[i]),
      .req_ready  (gen_req_ready[i]),
      .resp_valid (gen_resp_valid[i]),
      .resp_ready (gen_resp_ready[i]),
      .stats      (gen_stats[i]),
      .done       (gen_done[i])
    );
  end

  perf_write_arb write_arb_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .gen_req_valid (gen_req_valid),
    .gen_req       (gen_req),
    .gen_req_ready (gen_req_ready),
    .gen_resp_valid(gen_resp_valid),
    .gen_resp_ready(gen_resp_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_gen   (mem_req_gen),
    .mem_req_ready (mem_req_ready),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp      (mem_resp),
    .mem_resp_ready(mem_resp_ready)
  );

  perf_wr_mem wr_mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (mem_req_valid),
    .req       (mem_req),
    .req_gen   (mem_req_gen),
    .req_ready (mem_req_ready),
    .resp_valid(mem_resp_valid),
    .resp      (mem_resp),
    .resp_ready(mem_resp_ready),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data)
  );

  //////////////////////////////////////////////////
  // report path
  //////////////////////////////////////////////////

  perf_reporter reporter_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .gen_done (gen_done),
    .gen_stats(gen_stats),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .done     (done)
  );

  perf_uart_tx uart_tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_valid(tx_valid),
    .tx_byte (tx_byte),
    .tx_ready(tx_ready),
    .utx_pin (utx_pin)
  );

endmodule

// ==== hdl/perf_pkg.sv ====
package perf_pkg;

  //////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////

  localparam int addr_w    = 8;
  localparam int data_w    = 16;
  localparam int num_gen   = 2;
  localparam int gen_w     = $clog2(num_gen);
  localparam int mem_depth = 256;

  // uart bit period, kept short so a frame fits a quick simulation.
  localparam int clks_per_bit = 8;
  localparam int baud_cnt_w   = $clog2(clks_per_bit);

  localparam logic [15:0] lfsr_taps = 16'hB400;
  localparam logic [15:0] lfsr_seed = 16'h1ACE;

  // header byte, then count and checksum per generator, high byte first.
  localparam logic [7:0] report_header = 8'hA5;
  localparam int         report_bytes  = 1 + 4 * num_gen;
  localparam int         rep_idx_w     = $clog2(report_bytes);

  //////////////////////////////////////////////////
  // channel payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic [gen_w-1:0] gen;
  } wr_resp_t;

  typedef struct packed {
    logic [15:0] count;
    logic [15:0] checksum;
  } gen_stats_t;

  typedef enum logic [1:0] {
    gen_idle,
    gen_issue,
    gen_wait_resp,
    gen_done
  } gen_state_e;

  typedef enum logic [1:0] {
    rep_idle,
    rep_wait,
    rep_send,
    rep_done
  } rep_state_e;

  typedef enum logic [1:0] {
    arb_idle,
    arb_req,
    arb_resp
  } arb_state_e;

endpackage

// ==== hdl/perf_reporter.sv ====
`timescale 1ns/1ps

module perf_reporter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [perf_pkg::num_gen-1:0] gen_done,
  input  perf_pkg::gen_stats_t         gen_stats [perf_pkg::num_gen],
  output logic                         tx_valid,
  output logic [7:0]                   tx_byte,
  input  logic                         tx_ready,
  output logic                         done
);
  import perf_pkg::*;

  rep_state_e           state;
  logic [rep_idx_w-1:0] idx;
  logic                 draining;
  logic [7:0]           frame [report_bytes];

  always_comb begin
    frame[0] = report_header;
    for (int g = 0; g < num_gen; g++) begin
      frame[4*g+1] = gen_stats[g].count[15:8];
      frame[4*g+2] = gen_stats[g].count[7:0];
      frame[4*g+3] = gen_stats[g].checksum[15:8];
      frame[4*g+4] = gen_stats[g].checksum[7:0];
    end
  end

  assign tx_byte  = frame[idx];
  assign tx_valid = (state == rep_send) && !draining;
  assign done     = (state == rep_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rep_idle;
      idx      <= '0;
      draining <= 1'b0;
    end else begin
      case (state)
        rep_idle, rep_done: begin
          if (start) begin
            state <= rep_wait;
          end
        end
        rep_wait: begin
          if (&gen_done) begin
            idx      <= '0;
            draining <= 1'b0;
            state    <= rep_send;
          end
        end
        rep_send: begin
          // after the last byte, wait for the transmitter to go idle again.
          if (draining) begin
            if (tx_ready) begin
              state <= rep_done;
            end
          end else if (tx_ready) begin
            if (idx == rep_idx_w'(report_bytes - 1)) begin
              draining <= 1'b1;
            end else begin
              idx <= idx + 1'b1;
            end
          end
        end
        default: state <= rep_idle;
      endcase
    end
  end

endmodule

// ==== hdl/perf_traffic_gen.sv ====
`timescale 1ns/1ps

module perf_traffic_gen #(
  parameter int gen_id = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic [15:0]          write_count,
  output logic                 req_valid,
  output perf_pkg::wr_req_t    req,
  input  logic                 req_ready,
  input  logic                 resp_valid,
  output logic                 resp_ready,
  output perf_pkg::gen_stats_t stats,
  output logic                 done
);
  import perf_pkg::*;

  gen_state_e        state;
  logic [15:0]       remaining;
  logic [data_w-1:0] lfsr;
  logic [data_w-1:0] lfsr_next;
  logic [data_w-1:0] inflight_data;
  logic              launch;
  logic              req_fire;
  logic              resp_fire;

  assign lfsr_next  = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
  assign launch     = start && (state == gen_idle || state == gen_done);
  assign req_valid  = (state == gen_issue);
  assign resp_ready = (state == gen_wait_resp);
  assign done       = (state == gen_done);
  assign req_fire   = req_valid && req_ready;
  assign resp_fire  = resp_valid && resp_ready;

  // the top address bit selects this generator's half of the memory.
  assign req.addr = {gen_w'(gen_id), lfsr[addr_w-gen_w-1:0]};
  assign req.data = lfsr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= gen_idle;
      remaining <= '0;
      stats     <= '0;
    end else begin
      case (state)
        gen_idle, gen_done: begin
          if (start) begin
            stats     <= '0;
            remaining <= write_count;
            state     <= (write_count == 16'd0) ? gen_done : gen_issue;
          end
        end
        gen_issue: begin
          if (req_fire) begin
            remaining <= remaining - 16'd1;
            state     <= gen_wait_resp;
          end
        end
        gen_wait_resp: begin
          if (resp_fire) begin
            stats.count    <= stats.count + 16'd1;
            stats.checksum <= stats.checksum ^ inflight_data;
            state          <= (remaining == 16'd0) ? gen_done : gen_issue;
          end
        end
        default: state <= gen_idle;
      endcase
    end
  end

  // the lfsr steps on acceptance, so inflight_data keeps the word owed a response.
  always_ff @(posedge clk) begin
    if (launch) begin
      lfsr <= lfsr_seed ^ data_w'(gen_id);
    end else if (req_fire) begin
      lfsr          <= lfsr_next;
      inflight_data <= lfsr;
    end
  end

endmodule

// ==== hdl/perf_uart_tx.sv ====
`timescale 1ns/1ps

module perf_uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_valid,
  input  logic [7:0] tx_byte,
  output logic       tx_ready,
  output logic       utx_pin
);
  import perf_pkg::*;

  logic                  busy;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [3:0]            bit_cnt;
  logic [8:0]            shifter;
  logic                  bit_end;
  logic                  load;

  assign tx_ready = !busy;
  assign load     = tx_valid && tx_ready;
  assign bit_end  = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      utx_pin  <= 1'b1;
    end else if (load) begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      utx_pin  <= 1'b0;
    end else if (busy) begin
      baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
      if (bit_end) begin
        // bit 9 is the stop bit, the line stays high after it.
        if (bit_cnt == 4'd9) begin
          busy <= 1'b0;
        end else begin
          utx_pin <= shifter[0];
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shifter <= {1'b1, tx_byte};
    end else if (busy && bit_end) begin
      shifter <= {1'b1, shifter[8:1]};
    end
  end

endmodule

// ==== hdl/perf_wr_mem.sv ====
`timescale 1ns/1ps

module perf_wr_mem (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid,
  input  perf_pkg::wr_req_t           req,
  input  logic [perf_pkg::gen_w-1:0]  req_gen,
  output logic                        req_ready,
  output logic                        resp_valid,
  output perf_pkg::wr_resp_t          resp,
  input  logic                        resp_ready,
  input  logic [perf_pkg::addr_w-1:0] dbg_addr,
  output logic [perf_pkg::data_w-1:0] dbg_data
);
  import perf_pkg::*;

  logic [data_w-1:0] mem [mem_depth];
  logic              req_fire;

  // only one response may be pending, so a new write waits for its handshake.
  assign req_ready = !resp_valid;
  assign req_fire  = req_valid && req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (req_fire) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      mem[req.addr] <= req.data;
      resp.gen      <= req_gen;
    end
    dbg_data <= mem[dbg_addr];
  end

endmodule

// ==== hdl/perf_write_arb.sv ====
`timescale 1ns/1ps

module perf_write_arb (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [perf_pkg::num_gen-1:0] gen_req_valid,
  input  perf_pkg::wr_req_t            gen_req [perf_pkg::num_gen],
  output logic [perf_pkg::num_gen-1:0] gen_req_ready,
  output logic [perf_pkg::num_gen-1:0] gen_resp_valid,
  input  logic [perf_pkg::num_gen-1:0] gen_resp_ready,
  output logic                         mem_req_valid,
  output perf_pkg::wr_req_t            mem_req,
  output logic [perf_pkg::gen_w-1:0]   mem_req_gen,
  input  logic                         mem_req_ready,
  input  logic                         mem_resp_valid,
  input  perf_pkg::wr_resp_t           mem_resp,
  output logic                         mem_resp_ready
);
  import perf_pkg::*;

  arb_state_e       state;
  logic [gen_w-1:0] grant;
  logic [gen_w-1:0] last;
  logic [gen_w-1:0] pick;
  logic             pick_valid;

  // search starts one past the last winner and wraps around.
  always_comb begin
    int cand;
    pick       = last;
    pick_valid = 1'b0;
    for (int k = 1; k <= num_gen; k++) begin
      cand = (int'(last) + k) % num_gen;
      if (!pick_valid && gen_req_valid[cand]) begin
        pick       = gen_w'(cand);
        pick_valid = 1'b1;
      end
    end
  end

  assign mem_req_valid  = (state == arb_req) && gen_req_valid[grant];
  assign mem_req        = gen_req[grant];
  assign mem_req_gen    = grant;
  assign mem_resp_ready = (state == arb_resp) && gen_resp_ready[mem_resp.gen];

  always_comb begin
    gen_req_ready  = '0;
    gen_resp_valid = '0;
    if (state == arb_req) begin
      gen_req_ready[grant] = mem_req_ready;
    end
    if (state == arb_resp) begin
      gen_resp_valid[mem_resp.gen] = mem_resp_valid;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= arb_idle;
      grant <= '0;
      last  <= gen_w'(num_gen - 1);
    end else begin
      case (state)
        arb_idle: begin
          if (pick_valid) begin
            grant <= pick;
            last  <= pick;
            state <= arb_req;
          end
        end
        arb_req: begin
          if (mem_req_valid && mem_req_ready) begin
            state <= arb_resp;
          end
        end
        arb_resp: begin
          if (mem_resp_valid && mem_resp_ready) begin
            state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

endmodule

// ==== sources.f ====
hdl/perf_pkg.sv
hdl/perf_traffic_gen.sv
hdl/perf_write_arb.sv
hdl/perf_wr_mem.sv
hdl/perf_uart_tx.sv
hdl/perf_reporter.sv
hdl/perf_arb_mem.sv
dv/perf_arb_mem_tb.sv
